// ==== files.f ====
vdp_pkg.sv
vdp_if.sv
vdp_csr.sv
vdp_ctrl.sv
vdp_lane.sv
vdp_reduce.sv
vdp_top.sv
tb_clock.sv
vdp_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing --top-module vdp_tb -f files.f -Mdir obj_dir &&
  ./obj_dir/Vvdp_tb | tee /dev/stderr | grep -q "Finished with no errors" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// ==== vdp_tb.sv ====
module vdp_tb;

  localparam int LANES = 8;
  localparam logic [31:0] SEED = 32'h50649c01;
  // Worst case for one run at delay 3 plus its CSR traffic
  localparam int RUN_CYCLES = (2 * LANES + 1) * 5 + 40;
  // Room for eight such runs twenty times over
  localparam int MAX_CYCLES = 20 * 8 * RUN_CYCLES;

  logic                   clk;
  logic                   reset;
  logic                   csr_v;
  logic                   csr_we;
  vdp_pkg::vdp_csr_addr_t csr_addr;
  vdp_pkg::vdp_word_t     csr_wdata;
  vdp_pkg::vdp_word_t     csr_rdata;
  logic                   csr_rvalid;
  logic                   mem_req;
  logic                   mem_we;
  vdp_pkg::vdp_addr_t     mem_addr;
  vdp_pkg::vdp_word_t     mem_wdata;
  logic                   mem_rvalid;
  vdp_pkg::vdp_word_t     mem_rdata;

  vdp_pkg::vdp_word_t mem [256];
  logic [31:0]        rng;
  logic [31:0]        delay_rng;
  logic               max_delay;
  vdp_pkg::vdp_addr_t win_a;
  vdp_pkg::vdp_addr_t win_b;
  vdp_pkg::vdp_addr_t win_r;
  int                 req_count;
  int                 bad_count;
  int                 req_base;
  int                 bad_base;
  int                 errors;
  int                 test_err0;
  int                 tests;
  int                 failed;
  int                 cycles = 0;

  tb_clock clock_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  vdp_top #(.LANES(LANES)) dut_i (
    .clk_i        (clk),
    .reset_i      (reset),
    .csr_v_i      (csr_v),
    .csr_we_i     (csr_we),
    .csr_addr_i   (csr_addr),
    .csr_wdata_i  (csr_wdata),
    .csr_rdata_o  (csr_rdata),
    .csr_rvalid_o (csr_rvalid),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] word_idx(input vdp_pkg::vdp_addr_t addr);
    return addr[10:3];
  endfunction

  function automatic vdp_pkg::vdp_addr_t elem_addr(input vdp_pkg::vdp_addr_t base, input int i);
    return base + vdp_pkg::vdp_addr_t'(i) * vdp_pkg::WORD_BYTES;
  endfunction

  function automatic bit in_window(input vdp_pkg::vdp_addr_t addr,
                                   input vdp_pkg::vdp_addr_t base);
    return (addr >= base) && (addr < elem_addr(base, LANES));
  endfunction

  function automatic int clamp_len(input vdp_pkg::vdp_word_t len);
    return (len > 64'(LANES)) ? LANES : int'(len);
  endfunction

  // Wrapped sum of A[i]*B[i] below the clamped length
  function automatic vdp_pkg::vdp_word_t dot_ref(input vdp_pkg::vdp_addr_t a,
                                                 input vdp_pkg::vdp_addr_t b,
                                                 input vdp_pkg::vdp_word_t len);
    vdp_pkg::vdp_word_t acc;
    acc = '0;
    for (int i = 0; i < clamp_len(len); i++) begin
      acc = acc + mem[word_idx(elem_addr(a, i))] * mem[word_idx(elem_addr(b, i))];
    end
    return acc;
  endfunction

  // Memory answers each request after 0 to 3 idle cycles
  initial begin : memory_model
    int         delay;
    logic [7:0] idx;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    delay_rng  = SEED;
    req_count  = 0;
    bad_count  = 0;
    forever begin
      @(negedge clk);
      mem_rvalid = 1'b0;
      if (mem_req) begin
        req_count++;
        idx = word_idx(mem_addr);
        if (mem_we) begin
          if (mem_addr != win_r) bad_count++;
          mem[idx] = mem_wdata;
        end else if (!in_window(mem_addr, win_a) && !in_window(mem_addr, win_b)) begin
          bad_count++;
        end
        if (max_delay) begin
          delay = 3;
        end else begin
          delay_rng = xorshift(delay_rng);
          delay = int'(delay_rng % 4);
        end
        repeat (delay + 1) @(negedge clk);
        mem_rdata  = mem[idx];
        mem_rvalid = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic report_error(input string what, input vdp_pkg::vdp_word_t exp,
                              input vdp_pkg::vdp_word_t got);
    errors++;
    $display("ERROR %0t: %s expected %h got %h", $time, what, exp, got);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("Test %0d %s: passed", tests, name);
    end else begin
      failed++;
      $display("Test %0d %s: failed with %0d errors", tests, name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  task automatic csr_write(input vdp_pkg::vdp_csr_addr_t addr, input vdp_pkg::vdp_word_t data);
    csr_v     = 1'b1;
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk);
    csr_v  = 1'b0;
    csr_we = 1'b0;
    // Read valid is a pulse that only a read may raise
    if (csr_rvalid) begin
      errors++;
      $display("Write to offset %h at time %0t raised the read valid", addr, $time);
    end
  endtask

  task automatic csr_read(input vdp_pkg::vdp_csr_addr_t addr, output vdp_pkg::vdp_word_t data);
    csr_v    = 1'b1;
    csr_we   = 1'b0;
    csr_addr = addr;
    @(negedge clk);
    csr_v = 1'b0;
    if (!csr_rvalid) begin
      errors++;
      $display("Read of offset %h at time %0t got no valid one cycle later", addr, $time);
    end
    data = csr_rdata;
  endtask

  task automatic expect_csr(input vdp_pkg::vdp_csr_addr_t addr, input vdp_pkg::vdp_word_t exp,
                            input string what);
    vdp_pkg::vdp_word_t got;
    csr_read(addr, got);
    if (got != exp) report_error(what, exp, got);
  endtask

  task automatic fill_vector(input vdp_pkg::vdp_addr_t base, input int n);
    logic [31:0] hi;
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      hi  = rng;
      rng = xorshift(rng);
      mem[word_idx(elem_addr(base, i))] = {hi, rng};
    end
  endtask

  task automatic start_run(input vdp_pkg::vdp_addr_t a, input vdp_pkg::vdp_addr_t b,
                           input vdp_pkg::vdp_addr_t r, input vdp_pkg::vdp_word_t len);
    win_a = a;
    win_b = b;
    win_r = r;
    csr_write(vdp_pkg::CSR_A_PTR, 64'(a));
    csr_write(vdp_pkg::CSR_B_PTR, 64'(b));
    csr_write(vdp_pkg::CSR_RES_PTR, 64'(r));
    csr_write(vdp_pkg::CSR_LEN, len);
    req_base = req_count;
    bad_base = bad_count;
    csr_write(vdp_pkg::CSR_START, 64'd1);
    @(negedge clk);
    // First fetch is due two cycles after the start strobe
    if (clamp_len(len) > 0 && !mem_req) begin
      errors++;
      $display("No memory request two cycles after start at time %0t", $time);
    end
  endtask

  task automatic check_run(input vdp_pkg::vdp_addr_t a, input vdp_pkg::vdp_addr_t b,
                           input vdp_pkg::vdp_addr_t r, input vdp_pkg::vdp_word_t len);
    vdp_pkg::vdp_word_t exp;
    vdp_pkg::vdp_word_t status;
    status = '0;
    while (status[1] == 1'b0) csr_read(vdp_pkg::CSR_STATUS, status);
    exp = dot_ref(a, b, len);
    if (status[1:0] != 2'b10) report_error("status after run", 64'd2, status);
    expect_csr(vdp_pkg::CSR_RESULT, exp, "result register");
    if (mem[word_idx(r)] != exp) report_error("stored result", exp, mem[word_idx(r)]);
    if (req_count - req_base != 2 * clamp_len(len) + 1) begin
      report_error("memory request count", 64'(2 * clamp_len(len) + 1),
                   64'(req_count - req_base));
    end
    if (bad_count != bad_base) begin
      errors++;
      $display("A request went outside the vectors or the result word by time %0t", $time);
    end
  endtask

  task automatic csr_readback();
    expect_csr(vdp_pkg::CSR_STATUS, '0, "status after reset");
    expect_csr(vdp_pkg::CSR_RESULT, '0, "result after reset");
    csr_write(vdp_pkg::CSR_A_PTR, 64'h1234_5670);
    csr_write(vdp_pkg::CSR_B_PTR, 64'h89ab_cde8);
    csr_write(vdp_pkg::CSR_LEN, 64'h0123_4567_89ab_cdef);
    csr_write(vdp_pkg::CSR_RES_PTR, 64'h0bad_f008);
    expect_csr(vdp_pkg::CSR_A_PTR, 64'h1234_5670, "A pointer");
    expect_csr(vdp_pkg::CSR_B_PTR, 64'h89ab_cde8, "B pointer");
    expect_csr(vdp_pkg::CSR_LEN, 64'h0123_4567_89ab_cdef, "length");
    expect_csr(vdp_pkg::CSR_RES_PTR, 64'h0bad_f008, "result pointer");
    expect_csr(6'h38, '0, "unknown offset");
    end_test("CSR readback");
  endtask

  task automatic full_length_dot();
    fill_vector(32'h000, 8);
    fill_vector(32'h100, 8);
    start_run(32'h000, 32'h100, 32'h200, 64'd8);
    check_run(32'h000, 32'h100, 32'h200, 64'd8);
    end_test("full length");
  endtask

  task automatic short_after_full();
    fill_vector(32'h000, 8);
    fill_vector(32'h100, 8);
    start_run(32'h000, 32'h100, 32'h208, 64'd8);
    check_run(32'h000, 32'h100, 32'h208, 64'd8);
    // Fresh data makes any leftover lane show up in the sum
    fill_vector(32'h000, 8);
    fill_vector(32'h100, 8);
    start_run(32'h000, 32'h100, 32'h210, 64'd3);
    check_run(32'h000, 32'h100, 32'h210, 64'd3);
    end_test("short after full");
  endtask

  task automatic clamp_and_zero();
    fill_vector(32'h000, 12);
    fill_vector(32'h100, 12);
    start_run(32'h000, 32'h100, 32'h218, 64'd12);
    check_run(32'h000, 32'h100, 32'h218, 64'd12);
    mem[word_idx(32'h220)] = 64'hffff_0000_ffff_0000;
    start_run(32'h000, 32'h100, 32'h220, 64'd0);
    check_run(32'h000, 32'h100, 32'h220, 64'd0);
    end_test("clamp and zero length");
  endtask

  task automatic back_to_back();
    max_delay = 1'b1;
    fill_vector(32'h000, 8);
    fill_vector(32'h100, 8);
    start_run(32'h000, 32'h100, 32'h228, 64'd8);
    repeat (6) @(negedge clk);
    csr_write(vdp_pkg::CSR_START, 64'd1);
    check_run(32'h000, 32'h100, 32'h228, 64'd8);
    repeat (4) @(negedge clk);
    expect_csr(vdp_pkg::CSR_STATUS, 64'd2, "status after busy start");
    fill_vector(32'h080, 5);
    fill_vector(32'h180, 5);
    start_run(32'h080, 32'h180, 32'h230, 64'd5);
    check_run(32'h080, 32'h180, 32'h230, 64'd5);
    max_delay = 1'b0;
    end_test("back to back");
  endtask

  initial begin
    csr_v     = 1'b0;
    csr_we    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    max_delay = 1'b0;
    win_a     = '0;
    win_b     = '0;
    win_r     = '0;
    rng       = SEED;
    errors    = 0;
    test_err0 = 0;
    tests     = 0;
    failed    = 0;
    for (int i = 0; i < 256; i++) begin
      mem[8'(i)] = {32'(i) ^ 32'hc0de_0000, ~32'(i)};
    end
    @(negedge clk);
    while (reset) @(negedge clk);
    csr_readback();
    full_length_dot();
    short_after_full();
    clamp_and_zero();
    back_to_back();
    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset spans the first ten rising edges
  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== vdp_top.sv ====
module vdp_top #(
  parameter int LANES = 8
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   csr_v_i,
  input  logic                   csr_we_i,
  input  vdp_pkg::vdp_csr_addr_t csr_addr_i,
  input  vdp_pkg::vdp_word_t     csr_wdata_i,
  output vdp_pkg::vdp_word_t     csr_rdata_o,
  output logic                   csr_rvalid_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output vdp_pkg::vdp_addr_t     mem_addr_o,
  output vdp_pkg::vdp_word_t     mem_wdata_o,
  input  logic                   mem_rvalid_i,
  input  vdp_pkg::vdp_word_t     mem_rdata_i
);

  vdp_pkg::vdp_word_t [LANES-1:0] prods;
  vdp_pkg::vdp_word_t             sum;
  logic                           sum_v;
  logic                           go;

  vdp_cfg_if cfg_if ();

  vdp_lane_if #(.LANES(LANES)) lane_if ();

  vdp_csr csr_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .csr_v_i      (csr_v_i),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .csr_rvalid_o (csr_rvalid_o),
    .cfg_o        (cfg_if.csr)
  );

  vdp_ctrl #(.LANES(LANES)) ctrl_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .sum_v_i      (sum_v),
    .sum_i        (sum),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .go_o         (go),
    .cfg_i        (cfg_if.ctrl),
    .lane_o       (lane_if.ctrl)
  );

  for (genvar i = 0; i < LANES; i++) begin : lane_g
    vdp_lane lane_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .lane_idx_i (32'(i)),
      .prod_o     (prods[i]),
      .lane_i     (lane_if.lane)
    );
  end

  vdp_reduce #(.LANES(LANES)) reduce_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .go_i    (go),
    .prods_i (prods),
    .sum_v_o (sum_v),
    .sum_o   (sum)
  );

endmodule

// ==== vdp_reduce.sv ====
module vdp_reduce #(
  parameter int LANES = 8
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           go_i,
  input  vdp_pkg::vdp_word_t [LANES-1:0] prods_i,
  output logic                           sum_v_o,
  output vdp_pkg::vdp_word_t             sum_o
);

  localparam int LEVELS = $clog2(LANES);

  vdp_pkg::vdp_word_t sum_q;
  logic               sum_v_q;

  // Level l holds LANES >> l partial sums
  for (genvar l = 0; l <= LEVELS; l++) begin : lvl
    vdp_pkg::vdp_word_t v [LANES >> l];
    for (genvar j = 0; j < (LANES >> l); j++) begin : node
      if (l == 0) begin : leaf
        assign v[j] = prods_i[j];
      end else begin : add
        assign v[j] = lvl[l-1].v[2*j] + lvl[l-1].v[2*j+1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sum_v_q <= 1'b0;
    end else begin
      sum_v_q <= go_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (go_i) begin
      sum_q <= lvl[LEVELS].v[0];
    end
  end

  assign sum_v_o = sum_v_q;
  assign sum_o   = sum_q;

endmodule

// ==== vdp_lane.sv ====
module vdp_lane (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [31:0]        lane_idx_i,
  output vdp_pkg::vdp_word_t prod_o,
  vdp_lane_if.lane           lane_i
);

  vdp_pkg::vdp_word_t a_q;
  vdp_pkg::vdp_word_t b_q;
  vdp_pkg::vdp_word_t prod_q;
  logic               hit;

  assign hit = lane_i.wr && (32'(lane_i.idx) == lane_idx_i);

  always_ff @(posedge clk_i) begin
    if (reset_i || lane_i.clear) begin
      a_q <= '0;
      b_q <= '0;
    end else if (hit) begin
      if (lane_i.sel_b) begin
        b_q <= lane_i.data;
      end else begin
        a_q <= lane_i.data;
      end
    end
  end

  // Low half of the product only, sums wrap
  always_ff @(posedge clk_i) begin
    prod_q <= a_q * b_q;
  end

  assign prod_o = prod_q;

endmodule

// ==== vdp_ctrl.sv ====
module vdp_ctrl #(
  parameter int LANES = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               mem_rvalid_i,
  input  vdp_pkg::vdp_word_t mem_rdata_i,
  input  logic               sum_v_i,
  input  vdp_pkg::vdp_word_t sum_i,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output vdp_pkg::vdp_addr_t mem_addr_o,
  output vdp_pkg::vdp_word_t mem_wdata_o,
  output logic               go_o,
  vdp_cfg_if.ctrl            cfg_i,
  vdp_lane_if.ctrl           lane_o
);

  localparam int IDX_W = $clog2(LANES);
  localparam int CNT_W = IDX_W + 1;

  typedef enum logic [2:0] {
    IDLE,
    REQ,
    WAIT_DATA,
    REDUCE,
    STORE,
    WAIT_STORE
  } state_e;

  state_e             state_q;
  state_e             state_d;
  logic [IDX_W-1:0]   idx_q;
  logic [CNT_W-1:0]   len_q;
  logic [CNT_W-1:0]   len_clamp;
  logic               sel_b_q;
  logic               pend_q;
  logic               go_q;
  vdp_pkg::vdp_word_t sum_q;
  logic               launch;
  logic               rd_ok;
  logic               last_elem;
  vdp_pkg::vdp_addr_t base;

  assign len_clamp = (cfg_i.len > vdp_pkg::vdp_word_t'(LANES)) ? CNT_W'(LANES)
                                                                : cfg_i.len[CNT_W-1:0];
  assign launch    = (state_q == IDLE) && cfg_i.start;
  assign rd_ok     = (state_q == WAIT_DATA) && mem_rvalid_i;
  assign last_elem = ({1'b0, idx_q} == len_q - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       if (cfg_i.start) state_d = (len_clamp == '0) ? REDUCE : REQ;
      REQ:        state_d = WAIT_DATA;
      WAIT_DATA:  if (mem_rvalid_i) state_d = (last_elem && sel_b_q) ? REDUCE : REQ;
      REDUCE:     if (sum_v_i) state_d = STORE;
      STORE:      state_d = WAIT_STORE;
      WAIT_STORE: if (mem_rvalid_i) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
      len_q   <= '0;
      sel_b_q <= 1'b0;
      pend_q  <= 1'b0;
      go_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Lanes load, then products register, then the tree is sampled
      pend_q  <= (launch && len_clamp == '0) || (rd_ok && last_elem && sel_b_q);
      go_q    <= pend_q;
      if (launch) begin
        len_q   <= len_clamp;
        idx_q   <= '0;
        sel_b_q <= 1'b0;
      end else if (rd_ok) begin
        if (last_elem) begin
          idx_q   <= '0;
          sel_b_q <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sum_v_i) begin
      sum_q <= sum_i;
    end
  end

  assign base        = sel_b_q ? cfg_i.b_ptr : cfg_i.a_ptr;
  assign mem_req_o   = (state_q == REQ) || (state_q == STORE);
  assign mem_we_o    = (state_q == STORE);
  assign mem_addr_o  = (state_q == STORE) ? cfg_i.res_ptr
                     : base + vdp_pkg::vdp_addr_t'(idx_q) * vdp_pkg::WORD_BYTES;
  assign mem_wdata_o = sum_q;
  assign go_o        = go_q;

  assign cfg_i.busy   = (state_q != IDLE);
  assign cfg_i.done   = (state_q == WAIT_STORE) && mem_rvalid_i;
  assign cfg_i.result = sum_q;

  assign lane_o.clear = launch;
  assign lane_o.wr    = rd_ok;
  assign lane_o.sel_b = sel_b_q;
  assign lane_o.idx   = idx_q;
  assign lane_o.data  = mem_rdata_i;

endmodule

// ==== vdp_csr.sv ====
module vdp_csr (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   csr_v_i,
  input  logic                   csr_we_i,
  input  vdp_pkg::vdp_csr_addr_t csr_addr_i,
  input  vdp_pkg::vdp_word_t     csr_wdata_i,
  output vdp_pkg::vdp_word_t     csr_rdata_o,
  output logic                   csr_rvalid_o,
  vdp_cfg_if.csr                 cfg_o
);

  vdp_pkg::vdp_addr_t a_ptr_q;
  vdp_pkg::vdp_addr_t b_ptr_q;
  vdp_pkg::vdp_addr_t res_ptr_q;
  vdp_pkg::vdp_word_t len_q;
  vdp_pkg::vdp_word_t result_q;
  vdp_pkg::vdp_word_t rdata_q;
  vdp_pkg::vdp_word_t rd_mux;
  logic               done_q;
  logic               start_q;
  logic               rvalid_q;
  logic               wr;
  logic               rd;

  assign wr = csr_v_i & csr_we_i;
  assign rd = csr_v_i & ~csr_we_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_q   <= '0;
      b_ptr_q   <= '0;
      res_ptr_q <= '0;
      len_q     <= '0;
      result_q  <= '0;
      done_q    <= 1'b0;
      start_q   <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // A start that lands while a run is pending or active is dropped
      start_q  <= wr && (csr_addr_i == vdp_pkg::CSR_START) && !cfg_o.busy && !start_q;
      rvalid_q <= rd;
      if (wr) begin
        case (csr_addr_i)
          vdp_pkg::CSR_A_PTR:   a_ptr_q   <= csr_wdata_i[31:0];
          vdp_pkg::CSR_B_PTR:   b_ptr_q   <= csr_wdata_i[31:0];
          vdp_pkg::CSR_LEN:     len_q     <= csr_wdata_i;
          vdp_pkg::CSR_RES_PTR: res_ptr_q <= csr_wdata_i[31:0];
          default: ;
        endcase
      end
      if (start_q) begin
        done_q <= 1'b0;
      end else if (cfg_o.done) begin
        done_q <= 1'b1;
      end
      if (cfg_o.done) begin
        result_q <= cfg_o.result;
      end
    end
  end

  always_comb begin
    case (csr_addr_i)
      vdp_pkg::CSR_A_PTR:   rd_mux = vdp_pkg::vdp_word_t'(a_ptr_q);
      vdp_pkg::CSR_B_PTR:   rd_mux = vdp_pkg::vdp_word_t'(b_ptr_q);
      vdp_pkg::CSR_LEN:     rd_mux = len_q;
      vdp_pkg::CSR_STATUS:  rd_mux = {62'b0, done_q, cfg_o.busy};
      vdp_pkg::CSR_RES_PTR: rd_mux = vdp_pkg::vdp_word_t'(res_ptr_q);
      vdp_pkg::CSR_RESULT:  rd_mux = result_q;
      default:              rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      rdata_q <= rd_mux;
    end
  end

  assign csr_rdata_o  = rdata_q;
  assign csr_rvalid_o = rvalid_q;

  assign cfg_o.a_ptr   = a_ptr_q;
  assign cfg_o.b_ptr   = b_ptr_q;
  assign cfg_o.res_ptr = res_ptr_q;
  assign cfg_o.len     = len_q;
  assign cfg_o.start   = start_q;

endmodule

// ==== vdp_if.sv ====
interface vdp_cfg_if;

  vdp_pkg::vdp_addr_t a_ptr;
  vdp_pkg::vdp_addr_t b_ptr;
  vdp_pkg::vdp_addr_t res_ptr;
  vdp_pkg::vdp_word_t len;
  logic               start;
  logic               busy;
  // done pulses once per run, result is valid with it
  logic               done;
  vdp_pkg::vdp_word_t result;

  modport csr (
    output a_ptr, b_ptr, res_ptr, len, start,
    input  busy, done, result
  );

  modport ctrl (
    input  a_ptr, b_ptr, res_ptr, len, start,
    output busy, done, result
  );

endinterface

interface vdp_lane_if #(
  parameter int LANES = 8
);

  localparam int IDX_W = $clog2(LANES);

  logic               clear;
  logic               wr;
  logic               sel_b;
  logic [IDX_W-1:0]   idx;
  vdp_pkg::vdp_word_t data;

  modport ctrl (output clear, wr, sel_b, idx, data);

  modport lane (input clear, wr, sel_b, idx, data);

endinterface

// ==== vdp_pkg.sv ====
package vdp_pkg;

  // Data path word, also the width of every CSR
  typedef logic [63:0] vdp_word_t;

  // Byte address into the shared memory
  typedef logic [31:0] vdp_addr_t;

  // Byte offset into the register file
  typedef logic [5:0] vdp_csr_addr_t;

  // Register map
  localparam vdp_csr_addr_t CSR_A_PTR   = 6'h00;
  localparam vdp_csr_addr_t CSR_B_PTR   = 6'h08;
  localparam vdp_csr_addr_t CSR_LEN     = 6'h10;
  localparam vdp_csr_addr_t CSR_START   = 6'h18;
  localparam vdp_csr_addr_t CSR_STATUS  = 6'h20;
  localparam vdp_csr_addr_t CSR_RES_PTR = 6'h28;
  localparam vdp_csr_addr_t CSR_RESULT  = 6'h30;

  // Address step between consecutive vector elements
  localparam int unsigned WORD_BYTES = 8;

endpackage
